// File: verilog.f
source/common.sv
source/microcode.sv
source/control_logic.sv
source/datapath.sv
source/mem_arbiter.sv
source/cpu_top.sv
test/clock_gen.sv
test/control_props.sv
test/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/cpu_tb.sv
`timescale 1ns/1ns
module cpu_tb;
  localparam int ADDR_BITS = 8;

  logic                 clk;
  logic                 rst_n;
  logic                 run;
  logic                 host_en;
  logic                 host_we;
  logic [ADDR_BITS-1:0] host_addr;
  logic [31:0]          host_wdata;
  logic [31:0]          host_rdata;
  logic                 fetch_strobe;
  logic [5:0]           cur_opcode;

  integer      seed = 32'hf9b3;
  int          errors = 0;
  int          checks = 0;
  int          strobes = 0;
  int          budget = 200; // Cycle budget, grows with every test step.
  int          elapsed = 0;
  logic [31:0] prog [$];    // Program image, word 0 first.
  int          prog_cycles;  // Expected cycles up to the final loop fetch.
  int          prog_instrs;  // Instructions that must pulse fetch_strobe.

  clock_gen #(.PERIOD(40)) i_clock_gen (.clk);

  cpu_top #(.MEM_ADDR_BITS(ADDR_BITS)) i_cpu_top (
    .clk, .rst_n, .run, .host_en, .host_we, .host_addr, .host_wdata,
    .host_rdata, .fetch_strobe, .cur_opcode
  );

  always @(posedge clk) begin
    if (!rst_n) strobes <= 0;
    else if (fetch_strobe) strobes <= strobes + 1; // One per instruction start.
  end

  always @(posedge clk) begin // Watchdog.
    elapsed <= elapsed + 1;
    if (elapsed > budget) begin
      $display("Watchdog expired after %0d cycles, the run is stuck", elapsed);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] ra,
                                        input logic [4:0] rb, input logic [15:0] imm);
    return {op, ra, rb, imm};
  endfunction

  function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] ra,
                                        input logic [4:0] rb, input logic [4:0] rc);
    return {op, ra, rb, rc, 11'd0};
  endfunction

  task automatic host_write(input logic [ADDR_BITS-1:0] a, input logic [31:0] d);
    budget += 2;
    @(posedge clk);
    host_en    <= 1'b1;
    host_we    <= 1'b1;
    host_addr  <= a;
    host_wdata <= d;
    @(posedge clk);
    host_en <= 1'b0; // Write lands on this edge.
  endtask

  task automatic host_read(input logic [ADDR_BITS-1:0] a, output logic [31:0] d);
    budget += 2;
    @(posedge clk);
    host_en   <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= a;
    @(posedge clk);
    host_en <= 1'b0;
    @(negedge clk);
    d = host_rdata; // Registered one cycle after the request.
  endtask

  task automatic expect_word(input logic [ADDR_BITS-1:0] a, input logic [31:0] exp,
                             input string what);
    logic [31:0] d;
    host_read(a, d);
    check_value(what, d, exp);
  endtask

  task automatic emit(input logic [31:0] word, input int cycles);
    prog.push_back(word);
    prog_cycles += 5 + cycles; // Fetch plus execute.
    prog_instrs++;
  endtask

  task automatic emit_skipped(input logic [31:0] word);
    prog.push_back(word); // Jumped over, costs nothing.
  endtask

  task automatic begin_prog;
    prog.delete();
    prog_cycles = 2; // Reset opcode steps.
    prog_instrs = 0;
    emit(enc_i(common::OP_LHU, 5'd1, 5'd0, 16'd0), 2); // r1 feeds the final loop.
  endtask

  task automatic end_prog;
    prog.push_back(enc_i(common::OP_BEQ, 5'd1, 5'd1, 16'hffff)); // Self-loop.
    prog_cycles += 5;
    prog_instrs++;
  endtask

  task automatic load_word(input logic [4:0] rd, input logic [7:0] a);
    emit(enc_i(common::OP_LHU, 5'd5, 5'd0, {8'd0, a}), 2);
    emit(enc_i(common::OP_LW, rd, 5'd5, 16'd0), 3);
  endtask

  task automatic store_reg(input logic [7:0] a, input logic [4:0] rs);
    emit(enc_i(common::OP_LHU, 5'd12, 5'd0, {8'd0, a}), 2);
    emit(enc_i(common::OP_SW, 5'd12, rs, 16'd0), 3);
  endtask

  task automatic fill_words(input int lo, input int hi);
    for (int a = lo; a <= hi; a++) begin
      host_write(ADDR_BITS'(a), 32'h5a5a_0000 ^ (32'(a) * 32'h0101_0101));
    end
  endtask

  // Load, reset, run until the final loop is fetched, then stop.
  task automatic run_program(input bit disturb);
    int limit;
    int cyc;
    for (int i = 0; i < prog.size(); i++) host_write(ADDR_BITS'(i), prog[i]);
    limit = disturb ? 2 * prog_cycles + 20 : prog_cycles + 20;
    budget += limit + 20;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    run   <= 1'b1;
    cyc = 0;
    while (strobes != prog_instrs && cyc < limit) begin
      @(posedge clk);
      cyc++;
      if (disturb) begin // Three host reads every twelve cycles.
        host_en   <= (cyc % 12) < 3;
        host_we   <= 1'b0;
        host_addr <= 8'd200;
      end
    end
    host_en <= 1'b0;
    if (strobes != prog_instrs) begin
      errors++;
      $display("Program did not reach its final loop within %0d cycles", limit);
    end
    repeat (6) @(posedge clk); // Short of the next loop fetch.
    @(negedge clk);
    check_value("fetch strobe count", 32'(strobes), 32'(prog_instrs));
    check_value("opcode in final loop", 32'(cur_opcode), 32'(common::OP_BEQ));
    @(posedge clk);
    run <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value("opcode with run low", 32'(cur_opcode), 32'(common::OP_RESET));
  endtask

  task automatic host_memory_roundtrip;
    logic [31:0] w [8];
    for (int i = 0; i < 8; i++) begin
      w[i] = $random(seed);
      host_write(ADDR_BITS'(100 + i), w[i]);
    end
    for (int i = 0; i < 8; i++) expect_word(ADDR_BITS'(100 + i), w[i], "host readback");
  endtask

  task automatic immediate_loads;
    logic [15:0] imm1;
    logic [15:0] imm2;
    imm1 = 16'($random(seed));
    imm2 = 16'($random(seed)) | 16'h8000; // Negative for the sign check.
    fill_words(128, 129);
    begin_prog;
    emit(enc_i(common::OP_LHU, 5'd2, 5'd0, imm1), 2);
    emit(enc_i(common::OP_LH, 5'd3, 5'd0, imm2), 3);
    store_reg(8'd128, 5'd2);
    store_reg(8'd129, 5'd3);
    end_prog;
    run_program(1'b0);
    expect_word(8'd128, {16'd0, imm1}, "LHU zero-extend");
    expect_word(8'd129, {{16{imm2[15]}}, imm2}, "LH sign-extend");
  endtask

  task automatic alu_operations;
    logic [31:0] a;
    logic [31:0] b;
    logic [15:0] imm;
    logic [4:0]  sh;
    a   = $random(seed);
    b   = $random(seed);
    imm = 16'($random(seed));
    sh  = 5'($random(seed));
    host_write(8'd64, a);
    host_write(8'd65, b);
    fill_words(130, 133);
    begin_prog;
    load_word(5'd6, 8'd64);
    load_word(5'd7, 8'd65);
    emit(enc_i(common::OP_ADDU, 5'd8, 5'd6, imm), 4);
    emit(enc_r(common::OP_ADD3, 5'd9, 5'd6, 5'd7), 4);
    emit(enc_r(common::OP_OR3, 5'd10, 5'd6, 5'd7), 4);
    emit(enc_i(common::OP_SLL, 5'd11, 5'd6, {11'd0, sh}), 4);
    store_reg(8'd130, 5'd8);
    store_reg(8'd131, 5'd9);
    store_reg(8'd132, 5'd10);
    store_reg(8'd133, 5'd11);
    end_prog;
    run_program(1'b0);
    expect_word(8'd130, a + {16'd0, imm}, "ADDU sum");
    expect_word(8'd131, a + b, "ADD3 sum");
    expect_word(8'd132, a | b, "OR3 result");
    expect_word(8'd133, a << sh, "SLL result");
  endtask

  task automatic word_copy(input bit disturb);
    logic [31:0] w;
    w = $random(seed);
    host_write(8'd70, w);
    fill_words(140, 140);
    begin_prog;
    load_word(5'd6, 8'd70);
    store_reg(8'd140, 5'd6);
    end_prog;
    run_program(disturb);
    expect_word(8'd140, w, disturb ? "copy under host traffic" : "LW/SW copy");
  endtask

  task automatic branch_markers;
    for (int a = 150; a <= 153; a++) host_write(ADDR_BITS'(a), 32'd0);
    begin_prog;
    emit(enc_i(common::OP_LHU, 5'd2, 5'd0, 16'd5), 2);
    emit(enc_i(common::OP_LHU, 5'd3, 5'd0, 16'd5), 2);
    emit(enc_i(common::OP_LHU, 5'd4, 5'd0, 16'd7), 2);
    emit(enc_i(common::OP_LHU, 5'd14, 5'd0, 16'h00aa), 2); // Marker value.
    emit(enc_i(common::OP_LHU, 5'd13, 5'd0, 16'd150), 2);
    emit(enc_i(common::OP_BEQ, 5'd2, 5'd3, 16'd1), 9);     // Taken.
    emit_skipped(enc_i(common::OP_SW, 5'd13, 5'd14, 16'd0));
    emit(enc_i(common::OP_LHU, 5'd13, 5'd0, 16'd151), 2);
    emit(enc_i(common::OP_BNE, 5'd2, 5'd3, 16'd1), 4);     // Not taken.
    emit(enc_i(common::OP_SW, 5'd13, 5'd14, 16'd0), 3);
    emit(enc_i(common::OP_LHU, 5'd13, 5'd0, 16'd152), 2);
    emit(enc_i(common::OP_BNE, 5'd2, 5'd4, 16'd1), 9);     // Taken.
    emit_skipped(enc_i(common::OP_SW, 5'd13, 5'd14, 16'd0));
    emit(enc_i(common::OP_LHU, 5'd13, 5'd0, 16'd153), 2);
    emit(enc_i(common::OP_BEQ, 5'd2, 5'd4, 16'd1), 4);     // Not taken.
    emit(enc_i(common::OP_SW, 5'd13, 5'd14, 16'd0), 3);
    end_prog;
    run_program(1'b0);
    expect_word(8'd150, 32'd0, "BEQ taken skips store");
    expect_word(8'd151, 32'h00aa, "BNE not taken stores");
    expect_word(8'd152, 32'd0, "BNE taken skips store");
    expect_word(8'd153, 32'h00aa, "BEQ not taken stores");
  endtask

  initial begin
    rst_n      = 1'b0;
    run        = 1'b0;
    host_en    = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = 32'd0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    host_memory_roundtrip;
    immediate_loads;
    alu_operations;
    word_copy(1'b0);
    branch_markers;
    word_copy(1'b1);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end
endmodule

// File: test/control_props.sv
`timescale 1ns/1ns
module control_props (
  input logic       clk,
  input logic       rst_n,
  input logic       run,
  input logic       stall,
  input logic [31:0] ctrl_word,
  input logic [4:0] count_q,
  input logic [5:0] opcode_q
);
  // Misc field clears the counter at the next edge.
  assert property (@(posedge clk) disable iff (!rst_n)
    run && !stall && ctrl_word[common::CW_MISC_BIT] |=> count_q == 5'd0)
    else $error("micro-op counter not cleared by misc field");

  // A stalled micro-op repeats.
  assert property (@(posedge clk) disable iff (!rst_n)
    run && stall |=> $stable(count_q) && $stable(opcode_q))
    else $error("control state moved during stall");

  // Idle at reset step 0 while run is low.
  assert property (@(posedge clk) disable iff (!rst_n)
    !run |=> count_q == 5'd0 && opcode_q == common::OP_RESET)
    else $error("control state not idle with run low");
endmodule

bind control_logic control_props i_control_props (.*);

// File: test/clock_gen.sv
`timescale 1ns/1ns
module clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);
  initial begin
    clk = 1'b0; // Start low so the first edge is a rising one.
  end

  always begin
    #(PERIOD / 2) clk = ~clk;
  end
endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ns
module cpu_top #(
  parameter int MEM_ADDR_BITS = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     run,
  input  logic                     host_en,
  input  logic                     host_we,
  input  logic [MEM_ADDR_BITS-1:0] host_addr,
  input  logic [31:0]              host_wdata,
  output logic [31:0]              host_rdata,
  output logic                     fetch_strobe,
  output logic [5:0]               cur_opcode
);
  logic [11:0]              ucode_addr;
  logic [31:0]              ctrl_word;
  logic [31:0]              bus;
  logic [5:0]               opword_opcode;
  logic                     mlu_zero;
  logic                     mlu_carry;
  logic                     mlu_negative;
  logic                     mem_req;
  logic                     mem_we;
  logic [MEM_ADDR_BITS-1:0] mem_addr;
  logic [31:0]              mem_wdata;
  logic [31:0]              mem_rdata;
  logic                     stall;

  control_logic i_control_logic (
    .clk, .rst_n, .run, .stall, .ctrl_word, .bus, .opword_opcode,
    .mlu_zero, .mlu_carry, .mlu_negative, .ucode_addr, .fetch_strobe, .cur_opcode
  );

  microcode i_microcode (.addr(ucode_addr), .ctrl_word);

  datapath #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) i_datapath (
    .clk, .rst_n, .run, .stall, .ctrl_word, .mem_rdata, .bus, .opword_opcode,
    .mlu_zero, .mlu_carry, .mlu_negative, .mem_req, .mem_we, .mem_addr, .mem_wdata
  );

  mem_arbiter #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) i_mem_arbiter (
    .clk, .rst_n, .host_en, .host_we, .host_addr, .host_wdata,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .host_rdata, .mem_rdata, .stall
  );
endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ns
module mem_arbiter #(
  parameter int MEM_ADDR_BITS = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     host_en,
  input  logic                     host_we,
  input  logic [MEM_ADDR_BITS-1:0] host_addr,
  input  logic [31:0]              host_wdata,
  input  logic                     mem_req,
  input  logic                     mem_we,
  input  logic [MEM_ADDR_BITS-1:0] mem_addr,
  input  logic [31:0]              mem_wdata,
  output logic [31:0]              host_rdata,
  output logic [31:0]              mem_rdata,
  output logic                     stall
);
  logic [31:0] mem [2**MEM_ADDR_BITS];
  logic        cpu_write;

  // Host wins every conflict, the CPU retries its micro-op.
  assign stall     = mem_req && host_en;
  assign cpu_write = mem_req && mem_we && !host_en;

  always_ff @(posedge clk) begin
    if (host_en && host_we) begin
      mem[host_addr] <= host_wdata;
    end else if (cpu_write) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      host_rdata <= 32'd0;
    end else if (host_en && !host_we) begin
      host_rdata <= mem[host_addr]; // Valid one cycle after the request.
    end
  end

  assign mem_rdata = mem[mem_addr]; // Asynchronous read for the CPU.
endmodule

// File: source/datapath.sv
`timescale 1ns/1ns
module datapath #(
  parameter int MEM_ADDR_BITS = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     run,
  input  logic                     stall,
  input  logic [31:0]              ctrl_word,
  input  logic [31:0]              mem_rdata,
  output logic [31:0]              bus,
  output logic [5:0]               opword_opcode,
  output logic                     mlu_zero,
  output logic                     mlu_carry,
  output logic                     mlu_negative,
  output logic                     mem_req,
  output logic                     mem_we,
  output logic [MEM_ADDR_BITS-1:0] mem_addr,
  output logic [31:0]              mem_wdata
);
  logic [31:0] regs [32];  // r31 is the PC.
  logic [31:0] tmp0;
  logic [31:0] tmp1;
  logic [31:0] opword;
  logic [4:0]  reg_idx;
  logic [31:0] mlu_b;
  logic [32:0] mlu_sum;
  logic [31:0] mlu_out;
  logic [31:0] shift_out;
  logic        wr_en;

  wire [7:0] ctrl_data  = ctrl_word[common::CW_CTRL_DATA_LSB +: 8];
  wire [1:0] reg_sel    = ctrl_word[common::CW_REG_SEL_LSB +: 2];
  wire [3:0] out_sel    = ctrl_word[common::CW_OUT_LSB +: 4];
  wire [2:0] in_sel     = ctrl_word[common::CW_IN_LSB +: 3];
  wire [2:0] mlu_op     = ctrl_word[common::CW_MLU_OP_LSB +: 3];
  wire       mlu_cin    = ctrl_word[common::CW_MLU_CARRY_BIT];
  wire [1:0] shifter_op = ctrl_word[common::CW_SHIFTER_LSB +: 2];

  always_comb begin
    case (reg_sel)
      common::REG_SEL_OPWORD0: reg_idx = opword[25:21];
      common::REG_SEL_OPWORD1: reg_idx = opword[20:16];
      common::REG_SEL_OPWORD2: reg_idx = opword[15:11];
      default:                 reg_idx = ctrl_data[4:0]; // Fixed index, e.g. the PC.
    endcase
  end

  // MLU, subtract is TMP0 + ~TMP1 + 1.
  assign mlu_b        = (mlu_op == common::MLU_SUB) ? ~tmp1 : tmp1;
  assign mlu_sum      = {1'b0, tmp0} + {1'b0, mlu_b} + {32'd0, mlu_cin};
  assign mlu_out      = (mlu_op == common::MLU_OR) ? (tmp0 | tmp1) : mlu_sum[31:0];
  assign mlu_carry    = mlu_sum[32];
  assign mlu_zero     = mlu_out == 32'd0;
  assign mlu_negative = mlu_out[31];

  always_comb begin
    case (shifter_op)
      common::SHIFTER_NONE:      shift_out = tmp0;
      common::SHIFTER_LEFT:      shift_out = tmp0 << tmp1[4:0];
      common::SHIFTER_SIGNEXT16: shift_out = {{16{tmp0[15]}}, tmp0[15:0]};
      default:                   shift_out = 32'd0;
    endcase
  end

  always_comb begin
    case (out_sel)
      common::OUT_REG:              bus = regs[reg_idx];
      common::OUT_TMP0:             bus = tmp0;
      common::OUT_TMP1:             bus = tmp1;
      common::OUT_MMU:              bus = mem_rdata;
      common::OUT_MLU:              bus = mlu_out;
      common::OUT_SHIFTER:          bus = shift_out;
      common::OUT_CTRL_DATA:        bus = {24'd0, ctrl_data};
      common::OUT_OPWORD_IMMEDIATE: bus = {16'd0, opword[15:0]}; // Zero-extended.
      default:                      bus = 32'd0; // OUT_NONE idles at zero.
    endcase
  end

  assign wr_en = run && !stall;

  always_ff @(posedge clk) begin
    if (wr_en && in_sel == common::IN_REG) begin
      regs[reg_idx] <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tmp0   <= 32'd0;
      tmp1   <= 32'd0;
      opword <= 32'd0;
    end else if (wr_en) begin
      case (in_sel)
        common::IN_TMP0:   tmp0 <= bus;
        common::IN_TMP1:   tmp1 <= bus;
        common::IN_OPWORD: opword <= bus;
        default: ;
      endcase
    end
  end

  assign opword_opcode = opword[31:26];
  assign mem_req   = run && (out_sel == common::OUT_MMU || in_sel == common::IN_MMU);
  assign mem_we    = run && in_sel == common::IN_MMU;
  assign mem_addr  = tmp0[MEM_ADDR_BITS-1:0]; // Word address.
  assign mem_wdata = bus;
endmodule

// File: source/control_logic.sv
`timescale 1ns/1ns
module control_logic (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        run,
  input  logic        stall,
  input  logic [31:0] ctrl_word,
  input  logic [31:0] bus,
  input  logic [5:0]  opword_opcode,
  input  logic        mlu_zero,
  input  logic        mlu_carry,
  input  logic        mlu_negative,
  output logic [11:0] ucode_addr,
  output logic        fetch_strobe,
  output logic [5:0]  cur_opcode
);
  logic [5:0] opcode_q;    // Opcode register.
  logic [4:0] count_q;     // Micro-op counter.
  logic       cond_q;      // Latched condition bit.
  logic       cond_next;
  logic       load_opcode;
  logic       from_bus;
  logic       count_clear;

  assign load_opcode = ctrl_word[common::CW_IN_LSB +: 3] == common::IN_OPCODE;
  assign from_bus    = ctrl_word[common::CW_OPCODE_SEL_BIT] == common::OPCODE_SEL_FROM_BUS;
  assign count_clear = ctrl_word[common::CW_MISC_BIT] == common::MISC_RESET_MICROOP_COUNTER;

  always_comb begin
    case (ctrl_word[common::CW_COND_SEL_LSB +: 2])
      common::COND_SEL_MLU_ZERO:     cond_next = mlu_zero;
      common::COND_SEL_MLU_CARRY:    cond_next = mlu_carry;
      common::COND_SEL_MLU_NEGATIVE: cond_next = mlu_negative;
      default:                       cond_next = 1'b0; // No interrupt source.
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin // Idle at reset step 0.
      opcode_q <= common::OP_RESET;
      count_q  <= 5'd0;
      cond_q   <= 1'b0;
    end else if (!stall) begin // Stalled micro-op repeats.
      cond_q  <= cond_next;
      count_q <= count_clear ? 5'd0 : count_q + 5'd1;
      if (load_opcode) begin
        opcode_q <= from_bus ? bus[5:0] : opword_opcode;
      end
    end
  end

  assign ucode_addr   = {cond_q, opcode_q, count_q}; // Layout shared with microcode.
  assign cur_opcode   = opcode_q;
  // Decode step of fetch, one pulse per instruction.
  assign fetch_strobe = run && !stall && load_opcode && !from_bus;
endmodule

// File: source/microcode.sv
`timescale 1ns/1ns
module microcode (
  input  logic [11:0] addr,
  output logic [31:0] ctrl_word
);
  logic       cond_var;
  logic [5:0] opcode;
  logic [4:0] count;
  logic [7:0] ctrl_data;
  logic [1:0] reg_sel;
  logic [3:0] out_sel;
  logic [2:0] in_sel;
  logic       misc;
  logic [2:0] mlu_op;
  logic       mlu_cin;
  logic [1:0] shifter_op;
  logic       opcode_sel;
  logic [1:0] cond_sel;
  logic       go_fetch;
  logic       take_branch;

  // Address layout must match control_logic.
  assign cond_var = addr[11];
  assign opcode   = addr[10:5];
  assign count    = addr[4:0];

  // BEQ jumps on a zero difference, BNE on a nonzero one.
  assign take_branch = (opcode == common::OP_BEQ) ? cond_var : !cond_var;

  always_comb begin
    ctrl_data  = 8'd0;
    reg_sel    = common::REG_SEL_OPWORD0;
    out_sel    = common::OUT_NONE;
    in_sel     = 3'd0; // Nothing captures the bus.
    misc       = 1'b0;
    mlu_op     = common::MLU_ADD;
    mlu_cin    = 1'b0;
    shifter_op = common::SHIFTER_NONE;
    opcode_sel = common::OPCODE_SEL_FROM_OPWORD;
    cond_sel   = common::COND_SEL_MLU_ZERO;
    go_fetch   = 1'b0;
    case (opcode)
      common::OP_RESET: begin
        case (count)
          5'd0: begin // Clear the PC, the bus idles at zero.
            ctrl_data = 8'(common::REG_PC);
            reg_sel   = common::REG_SEL_CONTROL;
            in_sel    = common::IN_REG;
          end
          5'd1: go_fetch = 1'b1;
          default: ;
        endcase
      end
      common::OP_FETCH: begin
        case (count)
          5'd0: begin // PC into TMP0 to address memory.
            ctrl_data = 8'(common::REG_PC);
            reg_sel   = common::REG_SEL_CONTROL;
            out_sel   = common::OUT_REG;
            in_sel    = common::IN_TMP0;
          end
          5'd1: begin // Instruction word into opword.
            out_sel = common::OUT_MMU;
            in_sel  = common::IN_OPWORD;
          end
          5'd2: begin // Constant 1 into TMP1.
            ctrl_data = 8'd1;
            out_sel   = common::OUT_CTRL_DATA;
            in_sel    = common::IN_TMP1;
          end
          5'd3: begin // PC = PC + 1.
            ctrl_data = 8'(common::REG_PC);
            reg_sel   = common::REG_SEL_CONTROL;
            out_sel   = common::OUT_MLU;
            in_sel    = common::IN_REG;
          end
          5'd4: begin // Decode, opcode comes from the opword.
            in_sel = common::IN_OPCODE;
            misc   = common::MISC_RESET_MICROOP_COUNTER;
          end
          default: ;
        endcase
      end
      common::OP_LHU: begin
        case (count)
          5'd0: begin
            out_sel = common::OUT_OPWORD_IMMEDIATE;
            in_sel  = common::IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      common::OP_LH: begin
        case (count)
          5'd0: begin // Immediate into TMP0.
            out_sel = common::OUT_OPWORD_IMMEDIATE;
            in_sel  = common::IN_TMP0;
          end
          5'd1: begin // Sign-extend into rD.
            out_sel    = common::OUT_SHIFTER;
            shifter_op = common::SHIFTER_SIGNEXT16;
            in_sel     = common::IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      common::OP_SW, common::OP_LW: begin
        case (count)
          5'd0: begin // Address register into TMP0.
            reg_sel = (opcode == common::OP_SW) ? common::REG_SEL_OPWORD0
                                                : common::REG_SEL_OPWORD1;
            out_sel = common::OUT_REG;
            in_sel  = common::IN_TMP0;
          end
          5'd1: begin
            if (opcode == common::OP_SW) begin // rS to memory.
              reg_sel = common::REG_SEL_OPWORD1;
              out_sel = common::OUT_REG;
              in_sel  = common::IN_MMU;
            end else begin // Memory to rD.
              out_sel = common::OUT_MMU;
              in_sel  = common::IN_REG;
            end
          end
          default: go_fetch = 1'b1;
        endcase
      end
      common::OP_ADDU, common::OP_SLL, common::OP_ADD3, common::OP_OR3: begin
        case (count)
          5'd0: begin // rS or rA into TMP0.
            reg_sel = common::REG_SEL_OPWORD1;
            out_sel = common::OUT_REG;
            in_sel  = common::IN_TMP0;
          end
          5'd1: begin // Second operand into TMP1.
            reg_sel = common::REG_SEL_OPWORD2;
            out_sel = (opcode == common::OP_ADD3 || opcode == common::OP_OR3)
                      ? common::OUT_REG : common::OUT_OPWORD_IMMEDIATE;
            in_sel  = common::IN_TMP1;
          end
          5'd2: begin // Result into rD.
            in_sel     = common::IN_REG;
            out_sel    = (opcode == common::OP_SLL) ? common::OUT_SHIFTER : common::OUT_MLU;
            shifter_op = common::SHIFTER_LEFT;
            mlu_op     = (opcode == common::OP_OR3) ? common::MLU_OR : common::MLU_ADD;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      common::OP_BEQ, common::OP_BNE: begin
        case (count)
          5'd0: begin // rA into TMP0.
            out_sel = common::OUT_REG;
            in_sel  = common::IN_TMP0;
          end
          5'd1: begin // rB into TMP1.
            reg_sel = common::REG_SEL_OPWORD1;
            out_sel = common::OUT_REG;
            in_sel  = common::IN_TMP1;
          end
          5'd2: begin // Subtract, zero flag latched for the next step.
            mlu_op   = common::MLU_SUB;
            mlu_cin  = 1'b1;
            cond_sel = common::COND_SEL_MLU_ZERO;
          end
          5'd3: begin
            if (take_branch) begin // Offset into TMP0.
              out_sel = common::OUT_OPWORD_IMMEDIATE;
              in_sel  = common::IN_TMP0;
            end else begin
              go_fetch = 1'b1;
            end
          end
          5'd4: in_sel = common::IN_TMP1; // Clear TMP1 from the idle bus.
          5'd5: begin // Sign-extended offset into TMP1.
            out_sel    = common::OUT_SHIFTER;
            shifter_op = common::SHIFTER_SIGNEXT16;
            in_sel     = common::IN_TMP1;
          end
          5'd6, 5'd7: begin // PC into TMP0, then PC = PC + offset.
            ctrl_data = 8'(common::REG_PC);
            reg_sel   = common::REG_SEL_CONTROL;
            out_sel   = (count == 5'd6) ? common::OUT_REG : common::OUT_MLU;
            in_sel    = (count == 5'd6) ? common::IN_TMP0 : common::IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      default: go_fetch = 1'b1; // Unknown opcodes skip to the next fetch.
    endcase
    if (go_fetch) begin // Load OP_FETCH from the bus and restart the count.
      ctrl_data  = 8'(common::OP_FETCH);
      out_sel    = common::OUT_CTRL_DATA;
      in_sel     = common::IN_OPCODE;
      misc       = common::MISC_RESET_MICROOP_COUNTER;
      opcode_sel = common::OPCODE_SEL_FROM_BUS;
    end
  end

  always_comb begin
    ctrl_word = '0;
    ctrl_word[common::CW_CTRL_DATA_LSB +: 8] = ctrl_data;
    ctrl_word[common::CW_REG_SEL_LSB +: 2]   = reg_sel;
    ctrl_word[common::CW_OUT_LSB +: 4]       = out_sel;
    ctrl_word[common::CW_IN_LSB +: 3]        = in_sel;
    ctrl_word[common::CW_MISC_BIT]           = misc;
    ctrl_word[common::CW_MLU_OP_LSB +: 3]    = mlu_op;
    ctrl_word[common::CW_MLU_CARRY_BIT]      = mlu_cin;
    ctrl_word[common::CW_SHIFTER_LSB +: 2]   = shifter_op;
    ctrl_word[common::CW_OPCODE_SEL_BIT]     = opcode_sel;
    ctrl_word[common::CW_COND_SEL_LSB +: 2]  = cond_sel;
  end
endmodule

// File: source/common.sv
package common;
  // Opcodes, the top 6 bits of an instruction word.
  localparam logic [5:0] OP_RESET = 6'd0;
  localparam logic [5:0] OP_FETCH = 6'd1;
  localparam logic [5:0] OP_LHU   = 6'd2;  // rD = zeroext(I).
  localparam logic [5:0] OP_ADDU  = 6'd3;  // rD = rS + zeroext(I).
  localparam logic [5:0] OP_ADD3  = 6'd4;  // rD = rA + rB.
  localparam logic [5:0] OP_SW    = 6'd5;  // mem[rD] = rS.
  localparam logic [5:0] OP_OR3   = 6'd6;  // rD = rA | rB.
  localparam logic [5:0] OP_LH    = 6'd7;  // rD = signext(I).
  localparam logic [5:0] OP_BEQ   = 6'd8;  // if rA == rB then pc += signext(I).
  localparam logic [5:0] OP_LW    = 6'd9;  // rD = mem[rS].
  localparam logic [5:0] OP_SLL   = 6'd10; // rD = rS << I[4:0].
  localparam logic [5:0] OP_BNE   = 6'd11; // if rA != rB then pc += signext(I).

  // Bus sources.
  localparam logic [3:0] OUT_NONE             = 4'd0;
  localparam logic [3:0] OUT_REG              = 4'd1;
  localparam logic [3:0] OUT_TMP0             = 4'd2;
  localparam logic [3:0] OUT_TMP1             = 4'd3;
  localparam logic [3:0] OUT_MMU              = 4'd4;
  localparam logic [3:0] OUT_MLU              = 4'd5;
  localparam logic [3:0] OUT_SHIFTER          = 4'd6;
  localparam logic [3:0] OUT_CTRL_DATA        = 4'd8;
  localparam logic [3:0] OUT_OPWORD_IMMEDIATE = 4'd9;

  // Bus destinations, zero captures nothing.
  localparam logic [2:0] IN_REG    = 3'd1;
  localparam logic [2:0] IN_TMP0   = 3'd2;
  localparam logic [2:0] IN_TMP1   = 3'd3;
  localparam logic [2:0] IN_MMU    = 3'd4;
  localparam logic [2:0] IN_OPWORD = 3'd5;
  localparam logic [2:0] IN_OPCODE = 3'd6;

  localparam logic [1:0] REG_SEL_OPWORD0 = 2'd0; // Opword bits 25:21.
  localparam logic [1:0] REG_SEL_OPWORD1 = 2'd1; // Opword bits 20:16.
  localparam logic [1:0] REG_SEL_OPWORD2 = 2'd2; // Opword bits 15:11.
  localparam logic [1:0] REG_SEL_CONTROL = 2'd3; // ctrl_data bits 4:0.

  localparam logic MISC_RESET_MICROOP_COUNTER = 1'b1;
  localparam logic OPCODE_SEL_FROM_OPWORD     = 1'b0;
  localparam logic OPCODE_SEL_FROM_BUS        = 1'b1;

  localparam logic [1:0] COND_SEL_MLU_ZERO     = 2'd0;
  localparam logic [1:0] COND_SEL_MLU_CARRY    = 2'd1;
  localparam logic [1:0] COND_SEL_MLU_NEGATIVE = 2'd2;

  localparam logic [2:0] MLU_ADD = 3'd0;
  localparam logic [2:0] MLU_SUB = 3'd1; // Adds ~TMP1, carry-in completes the negate.
  localparam logic [2:0] MLU_OR  = 3'd2;

  localparam logic [1:0] SHIFTER_NONE      = 2'd0;
  localparam logic [1:0] SHIFTER_LEFT      = 2'd1;
  localparam logic [1:0] SHIFTER_SIGNEXT16 = 2'd2;

  localparam int REG_PC = 31; // r31 holds the program counter.

  // Control word layout; bit 24 and bits 31:28 stay zero.
  localparam int CW_CTRL_DATA_LSB  = 0;  // 8 bits.
  localparam int CW_REG_SEL_LSB    = 8;  // 2 bits.
  localparam int CW_OUT_LSB        = 10; // 4 bits.
  localparam int CW_IN_LSB         = 14; // 3 bits.
  localparam int CW_MISC_BIT       = 17;
  localparam int CW_MLU_OP_LSB     = 18; // 3 bits.
  localparam int CW_MLU_CARRY_BIT  = 21;
  localparam int CW_SHIFTER_LSB    = 22; // 2 bits.
  localparam int CW_OPCODE_SEL_BIT = 25;
  localparam int CW_COND_SEL_LSB   = 26; // 2 bits.
endpackage
